// ==== rtl/sm_stream_pkg.sv ====
`default_nettype none

package sm_stream_pkg;

	// Input word
	localparam int WORD_BYTES = 4;
	localparam int WORD_BITS = WORD_BYTES * 8;

	// Window history, previous words kept next to the current one
	localparam int HIST_WORDS = 2;
	localparam int WIN_BYTES = 8;
	localparam int WIN_BITS = WIN_BYTES * 8;

	// Lookup l is class l / NUM_OFFSETS at offset l % NUM_OFFSETS
	localparam int NUM_OFFSETS = 4;
	localparam int NUM_CLASSES = 2;
	localparam int NUM_LOOKUPS = NUM_CLASSES * NUM_OFFSETS;

	// Newest bytes kept per class
	localparam int CLASS_LEN [NUM_CLASSES] = '{8, 4};

	// Table index width per class
	localparam int CLASS_INDEX_BITS [NUM_CLASSES] = '{10, 8};
	localparam int MAX_INDEX_BITS = 10;

	// Odd multiplier of the hash
	localparam logic [WIN_BITS-1:0] HASH_MULT = 64'h9e3779b97f4a7c15;
	localparam int HASH_STAGES = 3;

	localparam int RID_WIDTH = 16;

endpackage

`default_nettype wire

// ==== rtl/sm_apb_pkg.sv ====
`default_nettype none

package sm_apb_pkg;

	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	// Register region layout
	typedef struct packed {
		logic       region;
		logic [6:0] spare;
		logic [1:0] sel;
		logic [1:0] byte_off;
	} apb_reg_view_t;

	// Table region layout
	typedef struct packed {
		logic       region;
		logic       tbl_class;
		logic [9:0] entry;
	} apb_table_view_t;

	// Region 0 holds registers, region 1 the rule tables
	typedef union packed {
		apb_reg_view_t   reg_view;
		apb_table_view_t table_view;
	} apb_addr_u;

	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_HITS = 2'd1;

	// Used flag in table write data, rule id in the low bits
	localparam int TBL_USED_BIT = 31;

endpackage

`default_nettype wire

// ==== rtl/match_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module match_ctrl import sm_stream_pkg::*, sm_apb_pkg::*; (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire  [APB_ADDR_W-1:0]     paddr,
	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire  [APB_DATA_W-1:0]     pwdata,
	output logic [APB_DATA_W-1:0]     prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  wire                       din_valid,
	input  wire                       din_sop,
	input  wire  [NUM_LOOKUPS-1:0]    match_valid,
	output logic                      accept,
	output logic [NUM_LOOKUPS-1:0]    lookup_valid,
	output logic [NUM_CLASSES-1:0]    tbl_we,
	output logic [MAX_INDEX_BITS-1:0] tbl_index,
	output logic [RID_WIDTH:0]        tbl_wdata
);

	apb_addr_u             addr;
	logic                  access;
	logic                  tbl_sel;
	logic                  tbl_range_err;
	logic                  reg_sel_ok;
	logic                  tbl_wr;
	logic                  ctrl_wr;
	logic                  hits_wr;
	logic                  enable;
	logic [APB_DATA_W-1:0] hit_count;
	logic [3:0]            hit_inc;
	logic [1:0]            run_len;
	logic [1:0]            cur_run;
	logic [4:0]            run_bytes;

	assign addr = paddr;
	assign access = psel && penable;
	assign tbl_sel = addr.table_view.region;

	// Class 1 table is shallower than the index field
	assign tbl_range_err = addr.table_view.tbl_class &&
		(addr.table_view.entry[MAX_INDEX_BITS-1:CLASS_INDEX_BITS[1]] != '0);

	assign reg_sel_ok = (addr.reg_view.sel == REG_CTRL) || (addr.reg_view.sel == REG_HITS);

	assign ctrl_wr = access && pwrite && !tbl_sel && (addr.reg_view.sel == REG_CTRL);
	assign hits_wr = access && pwrite && !tbl_sel && (addr.reg_view.sel == REG_HITS);
	assign tbl_wr = access && pwrite && tbl_sel && !tbl_range_err;

	assign pready = 1'b1;
	assign pslverr = access && (tbl_sel ? (!pwrite || tbl_range_err) : !reg_sel_ok);

	always_comb begin
		prdata = '0;
		if (access && !pwrite && !tbl_sel) begin
			case (addr.reg_view.sel)
				REG_CTRL: prdata[0] = enable;
				REG_HITS: prdata = hit_count;
				default: prdata = '0;
			endcase
		end
	end

	always_comb begin
		for (int c = 0; c < NUM_CLASSES; c++) begin
			tbl_we[c] = tbl_wr && (int'(addr.table_view.tbl_class) == c);
		end
	end

	assign tbl_index = addr.table_view.entry;
	assign tbl_wdata = {pwdata[TBL_USED_BIT], pwdata[RID_WIDTH-1:0]};

	always_comb begin
		hit_inc = '0;
		for (int i = 0; i < NUM_LOOKUPS; i++) begin
			hit_inc = hit_inc + 4'(match_valid[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable <= 1'b0;
			hit_count <= '0;
		end else begin
			if (ctrl_wr)
				enable <= pwdata[0];
			// Clear takes priority over this cycle's hits
			if (hits_wr)
				hit_count <= '0;
			else
				hit_count <= hit_count + APB_DATA_W'(hit_inc);
		end
	end

	assign accept = din_valid && enable;

	// Run length of the present word, saturating at 3
	always_comb begin
		if (din_sop)
			cur_run = 2'd1;
		else if (run_len == 2'd3)
			cur_run = 2'd3;
		else
			cur_run = run_len + 2'd1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			run_len <= '0;
		else if (accept)
			run_len <= cur_run;
	end

	// Bytes of the packet before the present word
	assign run_bytes = 5'(cur_run - 2'd1) * 5'(WORD_BYTES);

	always_comb begin
		for (int l = 0; l < NUM_LOOKUPS; l++) begin
			lookup_valid[l] = accept &&
				(run_bytes + 5'(l % NUM_OFFSETS + 1) >= 5'(CLASS_LEN[l / NUM_OFFSETS]));
		end
	end

	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (!rst_n) $rose(penable) |-> psel
	);

endmodule

`default_nettype wire

// ==== rtl/window_shift.sv ====
`default_nettype none
`timescale 1ns/100ps

module window_shift import sm_stream_pkg::*; (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire  [WORD_BITS-1:0]                din,
	input  wire                                 accept,
	output logic [NUM_LOOKUPS-1:0][WIN_BITS-1:0] windows
);

	localparam int STREAM_BYTES = (HIST_WORDS + 1) * WORD_BYTES;

	// Newer word in the upper half
	logic [HIST_WORDS*WORD_BITS-1:0] history;
	logic [STREAM_BYTES*8-1:0]       stream;

	always_ff @(posedge clk) begin
		if (!rst_n)
			history <= '0;
		else if (accept)
			history <= {din, history[HIST_WORDS*WORD_BITS-1:WORD_BITS]};
	end

	// Byte 0 is the oldest byte
	assign stream = {din, history};

	// Window k ends at byte k of the current word
	always_comb begin
		for (int l = 0; l < NUM_LOOKUPS; l++) begin
			windows[l] = stream[8 * (STREAM_BYTES - WORD_BYTES + l % NUM_OFFSETS + 1 - WIN_BYTES)
				+: WIN_BITS] &
				({WIN_BITS{1'b1}} << (8 * (WIN_BYTES - CLASS_LEN[l / NUM_OFFSETS])));
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mul_hash.sv ====
`default_nettype none
`timescale 1ns/100ps

module mul_hash import sm_stream_pkg::*; #(
	parameter int INDEX_BITS = 10
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire  [WIN_BITS-1:0]   window,
	input  wire                   window_valid,
	output logic [INDEX_BITS-1:0] index,
	output logic                  index_valid
);

	localparam int HALF = WIN_BITS / 2;
	localparam logic [HALF-1:0] MULT_LO = HASH_MULT[HALF-1:0];
	localparam logic [HALF-1:0] MULT_HI = HASH_MULT[WIN_BITS-1:HALF];

	logic [HASH_STAGES-1:0] vld_pipe;
	logic [WIN_BITS-1:0]    win_q;
	logic [WIN_BITS-1:0]    p_low;
	logic [HALF-1:0]        p_cross;
	logic [WIN_BITS-1:0]    product;

	always_ff @(posedge clk) begin
		if (!rst_n)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[HASH_STAGES-2:0], window_valid};
	end

	assign index_valid = vld_pipe[HASH_STAGES-1];

	// Only the low half of the cross terms reaches the low 64 bits
	always_ff @(posedge clk) begin
		win_q <= window;
		p_low <= WIN_BITS'(win_q[HALF-1:0]) * WIN_BITS'(MULT_LO);
		p_cross <= win_q[WIN_BITS-1:HALF] * MULT_LO + win_q[HALF-1:0] * MULT_HI;
		index <= product[WIN_BITS-1 -: INDEX_BITS];
	end

	assign product = p_low + {p_cross, {HALF{1'b0}}};

	a_index_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(index_valid)
	);

endmodule

`default_nettype wire

// ==== rtl/rule_table.sv ====
`default_nettype none
`timescale 1ns/100ps

module rule_table import sm_stream_pkg::*; #(
	parameter int INDEX_BITS = 10
) (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire  [NUM_OFFSETS-1:0][INDEX_BITS-1:0] rd_index,
	input  wire  [NUM_OFFSETS-1:0]               rd_valid,
	input  wire                                  we,
	input  wire  [MAX_INDEX_BITS-1:0]            wr_index,
	input  wire  [RID_WIDTH:0]                   wr_data,
	output logic [NUM_OFFSETS-1:0]               hit,
	output logic [NUM_OFFSETS-1:0][RID_WIDTH-1:0] rid
);

	localparam int DEPTH = 1 << INDEX_BITS;

	logic [DEPTH-1:0]     used;
	logic [RID_WIDTH-1:0] rid_mem [DEPTH];
	logic [INDEX_BITS-1:0] wr_addr;

	assign wr_addr = wr_index[INDEX_BITS-1:0];

	// Whole table swept to unused on reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			used <= '0;
		else if (we)
			used[wr_addr] <= wr_data[RID_WIDTH];
	end

	always_ff @(posedge clk) begin
		if (we)
			rid_mem[wr_addr] <= wr_data[RID_WIDTH-1:0];
	end

	// Reads see the content from before a same-cycle write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hit <= '0;
		end else begin
			for (int p = 0; p < NUM_OFFSETS; p++) begin
				hit[p] <= rd_valid[p] && used[rd_index[p]];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < NUM_OFFSETS; p++) begin
			rid[p] <= rid_mem[rd_index[p]];
		end
	end

	a_write_in_range: assert property (
		@(posedge clk) disable iff (!rst_n) we |-> (int'(wr_index) < DEPTH)
	);

endmodule

`default_nettype wire

// ==== rtl/string_match_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module string_match_top import sm_stream_pkg::*, sm_apb_pkg::*; (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire  [APB_ADDR_W-1:0]               paddr,
	input  wire                                 psel,
	input  wire                                 penable,
	input  wire                                 pwrite,
	input  wire  [APB_DATA_W-1:0]               pwdata,
	output wire  [APB_DATA_W-1:0]               prdata,
	output wire                                 pready,
	output wire                                 pslverr,
	input  wire  [WORD_BITS-1:0]                din,
	input  wire                                 din_valid,
	input  wire                                 din_sop,
	output wire  [NUM_LOOKUPS-1:0]              match_valid,
	output wire  [NUM_LOOKUPS-1:0][RID_WIDTH-1:0] match_rid
);

	wire                                  accept;
	wire [NUM_LOOKUPS-1:0]                lookup_valid;
	wire [NUM_LOOKUPS-1:0][WIN_BITS-1:0]  windows;
	wire [NUM_CLASSES-1:0]                tbl_we;
	wire [MAX_INDEX_BITS-1:0]             tbl_index;
	wire [RID_WIDTH:0]                    tbl_wdata;
	wire [NUM_OFFSETS-1:0][CLASS_INDEX_BITS[0]-1:0] idx_c0;
	wire [NUM_OFFSETS-1:0][CLASS_INDEX_BITS[1]-1:0] idx_c1;
	wire [NUM_OFFSETS-1:0]                idx_valid_c0;
	wire [NUM_OFFSETS-1:0]                idx_valid_c1;

	match_ctrl u_match_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.din_valid    (din_valid),
		.din_sop      (din_sop),
		.match_valid  (match_valid),
		.accept       (accept),
		.lookup_valid (lookup_valid),
		.tbl_we       (tbl_we),
		.tbl_index    (tbl_index),
		.tbl_wdata    (tbl_wdata)
	);

	window_shift u_window_shift (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (din),
		.accept  (accept),
		.windows (windows)
	);

	// One hash per class at every offset
	for (genvar k = 0; k < NUM_OFFSETS; k++) begin : g_hash
		mul_hash #(.INDEX_BITS(CLASS_INDEX_BITS[0])) u_hash_c0 (
			.clk          (clk),
			.rst_n        (rst_n),
			.window       (windows[k]),
			.window_valid (lookup_valid[k]),
			.index        (idx_c0[k]),
			.index_valid  (idx_valid_c0[k])
		);

		mul_hash #(.INDEX_BITS(CLASS_INDEX_BITS[1])) u_hash_c1 (
			.clk          (clk),
			.rst_n        (rst_n),
			.window       (windows[NUM_OFFSETS + k]),
			.window_valid (lookup_valid[NUM_OFFSETS + k]),
			.index        (idx_c1[k]),
			.index_valid  (idx_valid_c1[k])
		);
	end

	rule_table #(.INDEX_BITS(CLASS_INDEX_BITS[0])) u_table_c0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_index (idx_c0),
		.rd_valid (idx_valid_c0),
		.we       (tbl_we[0]),
		.wr_index (tbl_index),
		.wr_data  (tbl_wdata),
		.hit      (match_valid[NUM_OFFSETS-1:0]),
		.rid      (match_rid[NUM_OFFSETS-1:0])
	);

	rule_table #(.INDEX_BITS(CLASS_INDEX_BITS[1])) u_table_c1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_index (idx_c1),
		.rd_valid (idx_valid_c1),
		.we       (tbl_we[1]),
		.wr_index (tbl_index),
		.wr_data  (tbl_wdata),
		.hit      (match_valid[NUM_LOOKUPS-1:NUM_OFFSETS]),
		.rid      (match_rid[NUM_LOOKUPS-1:NUM_OFFSETS])
	);

endmodule

`default_nettype wire

// ==== testbench/match_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module match_checker import sm_stream_pkg::*, sm_apb_pkg::*; (
	input wire                               clk,
	input wire                               rst_n,
	input wire [APB_ADDR_W-1:0]              paddr,
	input wire                               psel,
	input wire                               penable,
	input wire                               pwrite,
	input wire [APB_DATA_W-1:0]              pwdata,
	input wire [APB_DATA_W-1:0]              prdata,
	input wire                               pready,
	input wire                               pslverr,
	input wire [WORD_BITS-1:0]               din,
	input wire                               din_valid,
	input wire                               din_sop,
	input wire [NUM_LOOKUPS-1:0]             match_valid,
	input wire [NUM_LOOKUPS-1:0][RID_WIDTH-1:0] match_rid
);

	int    err_count = 0;
	int    check_count = 0;
	int    test_count = 0;
	int    test_err_start = 0;
	string test_name = "idle";

	// Mirror of both rule tables
	// Class 1 only uses the first 256 entries
	logic                 tbl_used [2][1024];
	logic [RID_WIDTH-1:0] tbl_rid [2][1024];
	logic                 enable_m;
	logic [31:0]          hits_m;
	int                   run_m;
	logic [63:0]          hist_m;
	logic [7:0]           pipe_v [3];
	logic [9:0]           pipe_idx [3][8];
	logic [7:0]           exp_v;
	logic [RID_WIDTH-1:0] exp_rid [8];
	logic                 access;
	logic                 region;
	logic                 cls;
	logic [9:0]           idx;
	logic [1:0]           sel;
	logic [31:0]          exp_rd;
	logic                 exp_err;
	int                   r;

	// Window ending at byte k of the word with older bytes below
	function automatic logic [63:0] make_window(logic [63:0] hist, logic [31:0] word,
			int k, int c);
		logic [95:0] bytes;
		logic [63:0] w;
		bytes = {word, hist};
		w = bytes[8 * (k + 1) +: 64];
		if (c == 1)
			w[31:0] = '0;
		return w;
	endfunction

	function automatic logic [9:0] window_index(logic [63:0] w, int c);
		logic [63:0] prod;
		prod = w * HASH_MULT;
		if (c == 1)
			return {2'b00, prod[63:56]};
		return prod[63:54];
	endfunction

	task automatic report_error(string what, logic [31:0] exp, logic [31:0] act);
		err_count++;
		$display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic finish_test();
		if (err_count == test_err_start)
			$display("Test %s passed", test_name);
		else
			$display("Test %s failed with %0d errors", test_name, err_count - test_err_start);
	endtask

	task automatic report_summary();
		$display("Tests %0d, cycles checked %0d, errors %0d", test_count, check_count, err_count);
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int c = 0; c < 2; c++)
				for (int i = 0; i < 1024; i++)
					tbl_used[c][i] = 1'b0;
			for (int s = 0; s < 3; s++) begin
				pipe_v[s] = '0;
				for (int l = 0; l < 8; l++)
					pipe_idx[s][l] = '0;
			end
			enable_m = 1'b0;
			hits_m = '0;
			run_m = 0;
			hist_m = '0;
			exp_v = '0;
		end else begin
			check_count++;
			if (match_valid !== exp_v)
				report_error("match_valid", 32'(exp_v), 32'(match_valid));
			for (int l = 0; l < 8; l++)
				if (exp_v[l] && match_rid[l] !== exp_rid[l])
					report_error($sformatf("match_rid[%0d]", l), 32'(exp_rid[l]),
						32'(match_rid[l]));

			access = psel && penable;
			region = paddr[11];
			cls = paddr[10];
			idx = paddr[9:0];
			sel = paddr[3:2];
			if (access) begin
				exp_rd = '0;
				if (region)
					exp_err = !pwrite || (cls && idx >= 10'd256);
				else begin
					exp_err = (sel > 2'd1);
					if (!pwrite && sel == 2'd0)
						exp_rd = {31'b0, enable_m};
					else if (!pwrite && sel == 2'd1)
						exp_rd = hits_m;
				end
				if (pready !== 1'b1)
					report_error($sformatf("pready at %h", paddr), 32'(1'b1), 32'(pready));
				if (pslverr !== exp_err)
					report_error($sformatf("pslverr at %h", paddr), 32'(exp_err), 32'(pslverr));
				if (prdata !== exp_rd)
					report_error($sformatf("prdata at %h", paddr), exp_rd, prdata);
			end

			if (access && pwrite && !region && sel == 2'd1)
				hits_m = '0;
			else
				hits_m = hits_m + 32'($countones(exp_v));

			// Lookups reaching the tables on this edge see the old content
			for (int l = 0; l < 8; l++) begin
				exp_v[l] = pipe_v[2][l] && tbl_used[l / 4][pipe_idx[2][l]];
				exp_rid[l] = tbl_rid[l / 4][pipe_idx[2][l]];
			end
			pipe_v[2] = pipe_v[1];
			pipe_v[1] = pipe_v[0];
			pipe_idx[2] = pipe_idx[1];
			pipe_idx[1] = pipe_idx[0];
			pipe_v[0] = '0;
			if (enable_m && din_valid) begin
				r = din_sop ? 1 : ((run_m == 3) ? 3 : run_m + 1);
				for (int l = 0; l < 8; l++) begin
					pipe_idx[0][l] = window_index(make_window(hist_m, din, l % 4, l / 4), l / 4);
					pipe_v[0][l] = (4 * (r - 1) + l % 4 + 1) >= ((l / 4 == 1) ? 4 : 8);
				end
				run_m = r;
				hist_m = {din, hist_m[63:32]};
			end

			if (access && pwrite) begin
				if (region && !(cls && idx >= 10'd256)) begin
					tbl_used[cls][idx] = pwdata[31];
					tbl_rid[cls][idx] = pwdata[RID_WIDTH-1:0];
				end else if (!region && sel == 2'd0)
					enable_m = pwdata[0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_string_match.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_string_match import sm_stream_pkg::*, sm_apb_pkg::*; ();

	localparam int MAX_CYC = 1024;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic [11:0]          paddr;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	logic [31:0]          pwdata;
	wire  [31:0]          prdata;
	wire                  pready;
	wire                  pslverr;
	logic [31:0]          din;
	logic                 din_valid;
	logic                 din_sop;
	wire  [7:0]           match_valid;
	wire  [7:0][15:0]     match_rid;

	logic [31:0] s_word [MAX_CYC];
	logic        s_vld [MAX_CYC];
	logic        s_sop [MAX_CYC];
	int          s_len;
	logic [31:0] lfsr = 32'hb49a7552;
	logic [63:0] hist_tb = '0;
	logic [9:0]  plant_idx [$];
	logic        plant_cls [$];
	int          cycles = 0;
	int          budget = 40;

	always #10 clk = ~clk;

	string_match_top u_string_match_top (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .din(din), .din_valid(din_valid), .din_sop(din_sop),
		.match_valid(match_valid), .match_rid(match_rid)
	);

	match_checker u_match_checker (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .din(din), .din_valid(din_valid), .din_sop(din_sop),
		.match_valid(match_valid), .match_rid(match_rid)
	);

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		logic        b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h80200003;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	always @(posedge clk) begin
		cycles++;
		if (cycles > budget) begin
			$display("Timeout: run exceeded %0d cycles", budget);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic apb_access(logic [11:0] addr, logic wr, logic [31:0] data);
		budget += 6;
		@(negedge clk);
		paddr = addr;
		pwrite = wr;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		// Access phase lasts until the slave is ready
		@(posedge clk);
		while (pready !== 1'b1)
			@(posedge clk);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic table_write(logic c, logic [9:0] i, logic used, logic [15:0] rid);
		apb_access({1'b1, c, i}, 1'b1, {used, 15'b0, rid});
	endtask

	// Pre-generates a stream and picks windows to plant
	task automatic gen_stream(int n, int sop_span, int plant_lvl);
		int words;
		int left;
		words = 0;
		left = 0;
		s_len = 0;
		plant_idx.delete();
		plant_cls.delete();
		while (words < n && s_len < MAX_CYC) begin
			s_word[s_len] = rand_bits(32);
			if (rand_bits(2) == 0) begin
				s_vld[s_len] = 1'b0;
				s_sop[s_len] = rand_bits(1);
			end else begin
				s_vld[s_len] = 1'b1;
				s_sop[s_len] = (left == 0);
				if (left == 0)
					left = 4 + int'(rand_bits(4)) % (sop_span - 3);
				left--;
				for (int l = 0; l < 8; l++)
					if (int'(rand_bits(2)) < plant_lvl) begin
						plant_cls.push_back(l / 4);
						plant_idx.push_back(u_match_checker.window_index(
							u_match_checker.make_window(hist_tb, s_word[s_len], l % 4, l / 4), l / 4));
					end
				hist_tb = {s_word[s_len], hist_tb[63:32]};
				words++;
			end
			s_len++;
		end
		budget += 2 * s_len + 12;
	endtask

	task automatic plant_tables();
		logic c;
		for (int i = 0; i < plant_idx.size(); i++)
			table_write(plant_cls[i], plant_idx[i], 1'b1, rand_bits(16));
		for (int i = 0; i < 8; i++) begin
			c = rand_bits(1);
			table_write(c, c ? {2'b00, 8'(rand_bits(8))} : 10'(rand_bits(10)), rand_bits(1),
				rand_bits(16));
		end
	endtask

	// Clears the last planted entries and then writes an out-of-range alias of a live one
	task automatic rewrite_tables_midstream();
		int first;
		int probe;
		first = (plant_idx.size() > 12) ? plant_idx.size() - 12 : 0;
		probe = 0;
		for (int i = 0; i < first; i++)
			if (plant_cls[i])
				probe = i;
		for (int i = first; i < plant_idx.size(); i++)
			table_write(plant_cls[i], plant_idx[i], 1'b0, 16'h0);
		table_write(1'b1, {2'b01, plant_idx[probe][7:0]}, 1'b0, 16'h0);
	endtask

	task automatic send_stream();
		for (int i = 0; i < s_len; i++) begin
			@(negedge clk);
			din = s_word[i];
			din_valid = s_vld[i];
			din_sop = s_sop[i];
		end
		@(negedge clk);
		din_valid = 1'b0;
		din_sop = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	initial begin
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		din = '0;
		din_valid = 1'b0;
		din_sop = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		u_match_checker.start_test("reset_regs");
		apb_access(12'h000, 1'b0, 0);
		apb_access(12'h004, 1'b0, 0);
		apb_access(12'h000, 1'b1, 1);
		apb_access(12'h000, 1'b0, 0);
		apb_access(12'h000, 1'b1, 0);
		apb_access(12'h800, 1'b0, 0);
		apb_access(12'h008, 1'b0, 0);
		apb_access(12'h00c, 1'b1, 5);
		u_match_checker.finish_test();

		u_match_checker.start_test("disabled_stream");
		gen_stream(40, 12, 2);
		plant_tables();
		send_stream();
		apb_access(12'h004, 1'b0, 0);
		u_match_checker.finish_test();

		u_match_checker.start_test("lookups");
		gen_stream(150, 12, 1);
		plant_tables();
		apb_access(12'h000, 1'b1, 1);
		send_stream();
		apb_access(12'h004, 1'b0, 0);
		u_match_checker.finish_test();

		// Short packets with every window planted
		u_match_checker.start_test("packet_bounds");
		gen_stream(24, 5, 4);
		plant_tables();
		send_stream();
		u_match_checker.finish_test();

		u_match_checker.start_test("hit_counter");
		apb_access(12'h004, 1'b0, 0);
		apb_access(12'h004, 1'b1, 32'hffff);
		apb_access(12'h004, 1'b0, 0);
		u_match_checker.finish_test();

		u_match_checker.start_test("table_update");
		gen_stream(80, 12, 2);
		plant_tables();
		fork
			send_stream();
			begin
				repeat (40) @(negedge clk);
				rewrite_tables_midstream();
			end
		join
		apb_access(12'h004, 1'b0, 0);
		u_match_checker.finish_test();

		u_match_checker.report_summary();
		if (u_match_checker.err_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== string_match.f ====
rtl/sm_stream_pkg.sv
rtl/sm_apb_pkg.sv
rtl/match_ctrl.sv
rtl/window_shift.sv
rtl/mul_hash.sv
rtl/rule_table.sv
rtl/string_match_top.sv
testbench/match_checker.sv
testbench/tb_string_match.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the string_match testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal \
	-f string_match.f \
	--top-module tb_string_match \
	-o sim_string_match
if [ $? -ne 0 ]; then
	echo "Compile step failed"
	exit 1
fi

./obj_dir/sim_string_match > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
	exit 0
fi
exit 1
